// ==== rtl/soc_pkg.sv ====
// SoC package
// Word and byte types, memory size, UART bit timing, loader opcodes,
// reply codes and the state encodings of the UART and loader FSMs

package soc_pkg;

localparam int XLEN = 32;

typedef logic [XLEN-1:0] word_t;
typedef logic [7:0]      byte_t;

localparam int RAM_WORDS = 256;

typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t;  // Byte address bits 9:2

localparam int BAUD_DIV = 8;  // Clocks per UART bit, kept small for simulation

typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;

// Host opcodes, low bit selects the data bank
localparam byte_t OP_WR_IRAM = 8'h10;
localparam byte_t OP_WR_DRAM = 8'h11;
localparam byte_t OP_RD_IRAM = 8'h20;
localparam byte_t OP_RD_DRAM = 8'h21;
localparam byte_t OP_RUN     = 8'h30;
localparam byte_t OP_HALT    = 8'h31;

localparam byte_t RPL_ACK = 8'hAA;
localparam byte_t RPL_ERR = 8'hEE;

typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
} uart_state_t;

typedef enum logic [2:0] {
    LD_OPCODE,
    LD_ADDR,
    LD_DATA,
    LD_WRITE,
    LD_READ_WAIT,
    LD_REPLY
} loader_state_t;

endpackage

// ==== rtl/uart_rx.sv ====
// UART receiver
// 8N1 frames, each bit sampled near its middle, LSB first.
// A good frame is held valid until the loader takes it

`timescale 1ns/1ps

module uart_rx import soc_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,

    input  logic  uart_rx_i,
    input  logic  rx_data_rdy_i,

    output byte_t rx_data_o,
    output logic  rx_data_vld_o
);

uart_state_t state;

logic      rx_s1;
logic      rx_s2;
baud_cnt_t baud_cnt;
logic [2:0] bit_cnt;
byte_t     shift_q;

logic start_edge;
logic bit_end;
logic sample_bit;
logic stop_ok;

assign start_edge = rx_s2 & ~rx_s1;  // Falling edge seen one flop early
assign bit_end    = (baud_cnt == baud_cnt_t'(BAUD_DIV - 1));
assign sample_bit = (state == UART_DATA) && bit_end;
assign stop_ok    = (state == UART_STOP) && bit_end && rx_s2;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        rx_s1         <= 1'b1;
        rx_s2         <= 1'b1;
        state         <= UART_IDLE;
        baud_cnt      <= '0;
        bit_cnt       <= '0;
        rx_data_vld_o <= 1'b0;
    end else begin
        rx_s1 <= uart_rx_i;
        rx_s2 <= rx_s1;

        if (rx_data_vld_o && rx_data_rdy_i) begin
            rx_data_vld_o <= 1'b0;
        end

        case (state)
            UART_IDLE: begin
                baud_cnt <= '0;
                if (start_edge) begin
                    state <= UART_START;
                end
            end
            UART_START: begin
                if (baud_cnt == baud_cnt_t'(BAUD_DIV / 2 - 2)) begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= rx_s2 ? UART_IDLE : UART_DATA;  // Glitch, not a start bit
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
            UART_DATA: begin
                baud_cnt <= baud_cnt + 1'b1;
                if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= UART_STOP;
                    end
                end
            end
            UART_STOP: begin
                baud_cnt <= baud_cnt + 1'b1;
                if (bit_end) begin
                    state <= UART_IDLE;
                    if (rx_s2) begin
                        rx_data_vld_o <= 1'b1;  // Overwrites a byte not yet taken
                    end
                end
            end
            default: state <= UART_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (sample_bit) begin
        shift_q <= {rx_s2, shift_q[7:1]};
    end
    if (stop_ok) begin
        rx_data_o <= shift_q;
    end
end

endmodule

// ==== rtl/uart_tx.sv ====
// UART transmitter
// Sends a start bit, eight data bits LSB first and a stop bit,
// one bit every BAUD_DIV clocks. Ready only while idle

`timescale 1ns/1ps

module uart_tx import soc_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,

    input  byte_t tx_data_i,
    input  logic  tx_data_vld_i,

    output logic  uart_tx_o,
    output logic  tx_data_rdy_o
);

uart_state_t state;

logic [9:0] frame_q;  // Bit 0 is on the line
baud_cnt_t  baud_cnt;
logic [2:0] bit_cnt;
logic       bit_end;

assign bit_end       = (baud_cnt == baud_cnt_t'(BAUD_DIV - 1));
assign tx_data_rdy_o = (state == UART_IDLE);
assign uart_tx_o     = frame_q[0];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state    <= UART_IDLE;
        frame_q  <= '1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
    end else if (state == UART_IDLE) begin
        baud_cnt <= '0;
        bit_cnt  <= '0;
        if (tx_data_vld_i) begin
            frame_q <= {1'b1, tx_data_i, 1'b0};
            state   <= UART_START;
        end
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
        if (bit_end) begin
            frame_q <= {1'b1, frame_q[9:1]};  // Idle level shifts in behind
            case (state)
                UART_START: state <= UART_DATA;
                UART_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= UART_STOP;
                    end
                end
                default: state <= UART_IDLE;  // End of stop bit
            endcase
        end
    end
end

endmodule

// ==== rtl/ram.sv ====
// Instruction and data memory
// Two banks of RAM_WORDS words, one write port and one registered
// read port each. Contents are undefined until written

`timescale 1ns/1ps

module ram import soc_pkg::*; (
    input  logic      clk_i,

    input  ram_addr_t iram_rd_addr_i,
    input  ram_addr_t iram_wr_addr_i,
    input  word_t     iram_wr_data_i,
    input  logic      iram_wr_en_i,

    input  ram_addr_t dram_rd_addr_i,
    input  ram_addr_t dram_wr_addr_i,
    input  word_t     dram_wr_data_i,
    input  logic      dram_wr_en_i,

    output word_t     iram_rd_data_o,
    output word_t     dram_rd_data_o
);

word_t iram_mem [RAM_WORDS];
word_t dram_mem [RAM_WORDS];

always_ff @(posedge clk_i) begin
    if (iram_wr_en_i) begin
        iram_mem[iram_wr_addr_i] <= iram_wr_data_i;
    end
    iram_rd_data_o <= iram_mem[iram_rd_addr_i];  // Old data on a same-address write
end

always_ff @(posedge clk_i) begin
    if (dram_wr_en_i) begin
        dram_mem[dram_wr_addr_i] <= dram_wr_data_i;
    end
    dram_rd_data_o <= dram_mem[dram_rd_addr_i];
end

endmodule

// ==== rtl/ram_loader.sv ====
// Host command loader
// Parses byte commands from the UART, writes and reads the instruction
// and data banks, sends reply bytes and holds the CPU run level

`timescale 1ns/1ps

module ram_loader import soc_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    input  byte_t     rx_data_i,
    input  logic      rx_data_vld_i,
    input  logic      tx_data_rdy_i,

    input  word_t     iram_rd_data_i,
    input  word_t     dram_rd_data_i,

    output logic      rx_data_rdy_o,
    output byte_t     tx_data_o,
    output logic      tx_data_vld_o,

    output logic      cpu_run_o,

    output ram_addr_t iram_rd_addr_o,
    output ram_addr_t iram_wr_addr_o,
    output word_t     iram_wr_data_o,
    output logic      iram_wr_en_o,

    output ram_addr_t dram_rd_addr_o,
    output ram_addr_t dram_wr_addr_o,
    output word_t     dram_wr_data_o,
    output logic      dram_wr_en_o
);

loader_state_t state;

logic [1:0] cnt_q;    // Byte index, read wait phase or replies left
logic       run_q;

byte_t      op_q;
word_t      addr_q;
word_t      data_q;
word_t      reply_q;

logic       is_wr;
logic       rx_take;
logic       tx_take;
ram_addr_t  word_addr;

assign is_wr     = (op_q == OP_WR_IRAM) || (op_q == OP_WR_DRAM);
assign word_addr = addr_q[$clog2(RAM_WORDS)+1:2];  // Upper bits ignored, bank wraps

assign rx_data_rdy_o = (state == LD_OPCODE) || (state == LD_ADDR) || (state == LD_DATA);
assign tx_data_vld_o = (state == LD_REPLY);
assign tx_data_o     = reply_q[7:0];

assign rx_take = rx_data_vld_i && rx_data_rdy_o;
assign tx_take = tx_data_vld_o && tx_data_rdy_i;

assign cpu_run_o = run_q;

assign iram_rd_addr_o = word_addr;
assign dram_rd_addr_o = word_addr;
assign iram_wr_addr_o = word_addr;
assign dram_wr_addr_o = word_addr;
assign iram_wr_data_o = data_q;
assign dram_wr_data_o = data_q;
assign iram_wr_en_o   = (state == LD_WRITE) && !op_q[0];
assign dram_wr_en_o   = (state == LD_WRITE) && op_q[0];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state <= LD_OPCODE;
        cnt_q <= '0;
        run_q <= 1'b0;
    end else begin
        case (state)
            LD_OPCODE: begin
                cnt_q <= '0;
                if (rx_take) begin
                    case (rx_data_i)
                        OP_WR_IRAM, OP_WR_DRAM, OP_RD_IRAM, OP_RD_DRAM: state <= LD_ADDR;
                        OP_RUN: begin
                            run_q <= 1'b1;
                            state <= LD_REPLY;
                        end
                        OP_HALT: begin
                            run_q <= 1'b0;
                            state <= LD_REPLY;
                        end
                        default: state <= LD_REPLY;  // Error byte
                    endcase
                end
            end
            LD_ADDR: begin
                if (rx_take) begin
                    cnt_q <= cnt_q + 1'b1;  // Wraps to 0 after the last byte
                    if (cnt_q == 2'd3) begin
                        state <= is_wr ? LD_DATA : LD_READ_WAIT;
                    end
                end
            end
            LD_DATA: begin
                if (rx_take) begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 2'd3) begin
                        state <= LD_WRITE;
                    end
                end
            end
            LD_WRITE: begin
                cnt_q <= '0;
                state <= LD_REPLY;
            end
            LD_READ_WAIT: begin
                // First cycle presents the address, second latches the word
                if (cnt_q == 2'd0) begin
                    cnt_q <= 2'd1;
                end else begin
                    cnt_q <= 2'd3;
                    state <= LD_REPLY;
                end
            end
            LD_REPLY: begin
                if (tx_take) begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == 2'd0) begin
                        state <= LD_OPCODE;
                    end
                end
            end
            default: state <= LD_OPCODE;
        endcase
    end
end

// Command and reply payload
always_ff @(posedge clk_i) begin
    case (state)
        LD_OPCODE: begin
            if (rx_take) begin
                op_q    <= rx_data_i;
                reply_q <= ((rx_data_i == OP_RUN) || (rx_data_i == OP_HALT)) ?
                           word_t'(RPL_ACK) : word_t'(RPL_ERR);
            end
        end
        LD_ADDR: begin
            if (rx_take) begin
                addr_q <= {rx_data_i, addr_q[XLEN-1:8]};  // Little-endian
            end
        end
        LD_DATA: begin
            if (rx_take) begin
                data_q <= {rx_data_i, data_q[XLEN-1:8]};
            end
        end
        LD_WRITE: reply_q <= word_t'(RPL_ACK);
        LD_READ_WAIT: begin
            if (cnt_q != 2'd0) begin
                reply_q <= op_q[0] ? dram_rd_data_i : iram_rd_data_i;
            end
        end
        LD_REPLY: begin
            if (tx_take) begin
                reply_q <= reply_q >> 8;  // Next byte, LSB first
            end
        end
        default: ;
    endcase
end

endmodule

// ==== rtl/soc_top.sv ====
// Board top without the CPU
// UART receiver and transmitter, host command loader and the
// instruction/data memory. cpu_run_o stands for the CPU reset release

`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
    input  logic clk_i,
    input  logic reset_i,

    input  logic uart_rx_i,
    output logic uart_tx_o,

    output logic cpu_run_o
);

byte_t rx_data;
logic  rx_data_vld;
logic  rx_data_rdy;

byte_t tx_data;
logic  tx_data_vld;
logic  tx_data_rdy;

ram_addr_t iram_rd_addr;
ram_addr_t iram_wr_addr;
word_t     iram_wr_data;
logic      iram_wr_en;

ram_addr_t dram_rd_addr;
ram_addr_t dram_wr_addr;
word_t     dram_wr_data;
logic      dram_wr_en;

word_t iram_rd_data;
word_t dram_rd_data;

uart_rx uart_rx (
    .clk_i(clk_i),
    .reset_i(reset_i),

    .uart_rx_i(uart_rx_i),
    .rx_data_rdy_i(rx_data_rdy),

    .rx_data_o(rx_data),
    .rx_data_vld_o(rx_data_vld)
);

uart_tx uart_tx (
    .clk_i(clk_i),
    .reset_i(reset_i),

    .tx_data_i(tx_data),
    .tx_data_vld_i(tx_data_vld),

    .uart_tx_o(uart_tx_o),
    .tx_data_rdy_o(tx_data_rdy)
);

ram_loader ram_loader (
    .clk_i(clk_i),
    .reset_i(reset_i),

    .rx_data_i(rx_data),
    .rx_data_vld_i(rx_data_vld),
    .tx_data_rdy_i(tx_data_rdy),

    .iram_rd_data_i(iram_rd_data),
    .dram_rd_data_i(dram_rd_data),

    .rx_data_rdy_o(rx_data_rdy),
    .tx_data_o(tx_data),
    .tx_data_vld_o(tx_data_vld),

    .cpu_run_o(cpu_run_o),

    .iram_rd_addr_o(iram_rd_addr),
    .iram_wr_addr_o(iram_wr_addr),
    .iram_wr_data_o(iram_wr_data),
    .iram_wr_en_o(iram_wr_en),

    .dram_rd_addr_o(dram_rd_addr),
    .dram_wr_addr_o(dram_wr_addr),
    .dram_wr_data_o(dram_wr_data),
    .dram_wr_en_o(dram_wr_en)
);

ram ram (
    .clk_i(clk_i),

    .iram_rd_addr_i(iram_rd_addr),
    .iram_wr_addr_i(iram_wr_addr),
    .iram_wr_data_i(iram_wr_data),
    .iram_wr_en_i(iram_wr_en),

    .dram_rd_addr_i(dram_rd_addr),
    .dram_wr_addr_i(dram_wr_addr),
    .dram_wr_data_i(dram_wr_data),
    .dram_wr_en_i(dram_wr_en),

    .iram_rd_data_o(iram_rd_data),
    .dram_rd_data_o(dram_rd_data)
);

endmodule

// ==== testbench/tb_checker.sv ====
// Reply checker
// Decodes 8N1 frames on the transmit line, compares each byte against
// a FIFO of expected bytes and checks the run level on request

`timescale 1ns/1ps

module tb_checker import soc_pkg::*; #(
    parameter int NAME_CHARS = 16
) (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    uart_tx_i,
    input  logic                    cpu_run_i,

    input  logic                    exp_vld_i,
    input  byte_t                   exp_byte_i,
    input  logic [8*NAME_CHARS-1:0] exp_name_i,
    input  logic                    run_chk_i,
    input  logic                    exp_run_i,

    output logic                    idle_o,
    output int                      reply_errors_o,
    output int                      run_errors_o
);

byte_t                   exp_mem  [1024];
logic [8*NAME_CHARS-1:0] name_mem [1024];

logic [9:0] wr_ptr;
logic [9:0] rd_ptr;
logic       in_frame;

always @(posedge clk_i) begin
    if (reset_i) begin
        wr_ptr = '0;
        idle_o       <= 1'b1;
        run_errors_o <= 0;
    end else begin
        if (exp_vld_i) begin
            exp_mem[wr_ptr]  = exp_byte_i;
            name_mem[wr_ptr] = exp_name_i;
            wr_ptr = wr_ptr + 1'b1;
        end
        if (run_chk_i && (cpu_run_i !== exp_run_i)) begin
            $display("mismatch expected run level %0d actual %0d in test %s",
                     exp_run_i, cpu_run_i, exp_name_i);
            run_errors_o <= run_errors_o + 1;
        end
        idle_o <= (wr_ptr == rd_ptr) && !in_frame;  // All replies seen
    end
end

task automatic compare_byte(input byte_t got, input logic stop_bit);
    if (!stop_bit) begin
        $display("reply byte 0x%02h has a low stop bit", got);
        reply_errors_o = reply_errors_o + 1;
    end
    if (rd_ptr == wr_ptr) begin
        $display("unexpected reply byte 0x%02h while no reply was expected", got);
        reply_errors_o = reply_errors_o + 1;
    end else begin
        if (got !== exp_mem[rd_ptr]) begin
            $display("mismatch expected 0x%02h actual 0x%02h in test %s",
                     exp_mem[rd_ptr], got, name_mem[rd_ptr]);
            reply_errors_o = reply_errors_o + 1;
        end
        rd_ptr = rd_ptr + 1'b1;
    end
endtask

// Frame decoder, samples on the falling clock edge near mid-bit
initial begin
    byte_t rx_byte;
    logic  stop_bit;
    int    i;

    rd_ptr         = '0;
    in_frame       = 1'b0;
    reply_errors_o = 0;
    rx_byte        = '0;
    forever begin
        @(negedge clk_i);
        if (!reset_i && (uart_tx_i == 1'b0)) begin
            in_frame = 1'b1;
            repeat (BAUD_DIV / 2) @(negedge clk_i);
            if (uart_tx_i == 1'b0) begin
                for (i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk_i);
                    rx_byte = {uart_tx_i, rx_byte[7:1]};  // LSB first
                end
                repeat (BAUD_DIV) @(negedge clk_i);
                stop_bit = uart_tx_i;
                compare_byte(rx_byte, stop_bit);
            end else begin
                $display("short low pulse on the transmit line instead of a start bit");
                reply_errors_o = reply_errors_o + 1;
            end
            in_frame = 1'b0;
        end
    end
end

endmodule

// ==== testbench/tb_top.sv ====
// Loader testbench
// Reads host commands and expected replies from the stimulus file,
// sends them over the serial receive line and hands the expected
// bytes and run levels to the checker

`timescale 1ns/1ps

module tb_top import soc_pkg::*; ();

localparam int NAME_CHARS = 16;
localparam int MAX_GAP    = 20;  // Idle cycles between sent bytes

logic clk;
logic reset;
logic uart_rx;
logic uart_tx;
logic cpu_run;

logic                    exp_vld;
byte_t                   exp_byte;
logic [8*NAME_CHARS-1:0] exp_name;
logic                    run_chk;
logic                    exp_run;
logic                    reply_idle;
int                      reply_errors;
int                      run_errors;

int stim_errors;
int timeout_errors;
int cycle_limit;
int cycles;

string test_names[$];
int    send_counts[$];
int    reply_counts[$];
logic  exp_runs[$];
byte_t send_bytes[$];
byte_t reply_bytes[$];

soc_top dut_i (
    .clk_i(clk),
    .reset_i(reset),
    .uart_rx_i(uart_rx),
    .uart_tx_o(uart_tx),
    .cpu_run_o(cpu_run)
);

tb_checker #(.NAME_CHARS(NAME_CHARS)) checker_i (
    .clk_i(clk),
    .reset_i(reset),
    .uart_tx_i(uart_tx),
    .cpu_run_i(cpu_run),
    .exp_vld_i(exp_vld),
    .exp_byte_i(exp_byte),
    .exp_name_i(exp_name),
    .run_chk_i(run_chk),
    .exp_run_i(exp_run),
    .idle_o(reply_idle),
    .reply_errors_o(reply_errors),
    .run_errors_o(run_errors)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

function automatic logic [3:0] hex_digit(input byte c);
    byte v;
    if (c >= "a") begin
        v = c - 8'd87;
    end else if (c >= "A") begin
        v = c - 8'd55;
    end else begin
        v = c - 8'd48;
    end
    return v[3:0];
endfunction

// Padded with spaces so the name prints cleanly
function automatic logic [8*NAME_CHARS-1:0] name_bits(input string s);
    logic [8*NAME_CHARS-1:0] r;
    byte                     c;
    int                      i;
    r = '0;
    for (i = 0; i < NAME_CHARS; i++) begin
        c = (i < s.len()) ? s.getc(i) : 8'h20;
        r = {r[8*NAME_CHARS-9:0], c};
    end
    return r;
endfunction

task automatic split_bytes(input string s, input bit to_send, output int count);
    logic [7:0] acc;
    int         digits;
    int         i;
    count  = 0;
    digits = 0;
    acc    = '0;
    for (i = 0; i < s.len(); i++) begin
        if (s.getc(i) != ":") begin
            acc = {acc[3:0], hex_digit(s.getc(i))};
            digits++;
            if (digits == 2) begin
                if (to_send) begin
                    send_bytes.push_back(acc);
                end else begin
                    reply_bytes.push_back(acc);
                end
                count++;
                digits = 0;
            end
        end
    end
endtask

task automatic load_stimulus(output bit ok);
    int    fd;
    int    got;
    int    n_send;
    int    n_reply;
    int    run_lvl;
    string line;
    string name;
    string send_s;
    string reply_s;
    ok = 1'b1;
    fd = $fopen("testbench/uart_stimulus.txt", "r");
    if (fd == 0) begin
        $display("cannot open the stimulus file testbench/uart_stimulus.txt");
        ok = 1'b0;
    end else begin
        while ($fgets(line, fd) != 0) begin
            if ((line.len() > 1) && (line.getc(0) != "#")) begin
                got = $sscanf(line, "%s %s %s %d", name, send_s, reply_s, run_lvl);
                if (got != 4) begin
                    $display("stimulus line could not be read: %s", line);
                    ok = 1'b0;
                end else begin
                    split_bytes(send_s, 1'b1, n_send);
                    split_bytes(reply_s, 1'b0, n_reply);
                    test_names.push_back(name);
                    send_counts.push_back(n_send);
                    reply_counts.push_back(n_reply);
                    exp_runs.push_back(run_lvl != 0);
                end
            end
        end
        $fclose(fd);
    end
endtask

// 8N1 frame on the receive line, each bit BAUD_DIV cycles from a falling edge
task automatic send_byte(input byte_t b);
    byte_t bits;
    int    gap;
    int    i;
    bits    = b;
    uart_rx = 1'b0;
    repeat (BAUD_DIV) @(negedge clk);
    for (i = 0; i < 8; i++) begin
        uart_rx = bits[0];
        bits    = bits >> 1;
        repeat (BAUD_DIV) @(negedge clk);
    end
    uart_rx = 1'b1;
    repeat (BAUD_DIV) @(negedge clk);
    gap = $urandom_range(MAX_GAP, 0);
    repeat (gap) @(negedge clk);
endtask

task automatic request_run_check(input string name, input logic lvl);
    exp_name = name_bits(name);
    exp_run  = lvl;
    run_chk  = 1'b1;
    @(negedge clk);
    run_chk  = 1'b0;
endtask

task automatic end_run();
    int total;
    total = reply_errors + run_errors + stim_errors + timeout_errors;
    $display("errors: reply %0d, run level %0d, stimulus %0d, timeout %0d, total %0d",
             reply_errors, run_errors, stim_errors, timeout_errors, total);
    if (total == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
endtask

initial begin
    bit ok;
    int seed;
    int t;
    int k;
    int sp;
    int rp;

    seed     = $urandom(21929);
    uart_rx  = 1'b1;
    reset    = 1'b1;
    exp_vld  = 1'b0;
    exp_byte = '0;
    exp_name = '0;
    run_chk  = 1'b0;
    exp_run  = 1'b0;
    stim_errors = 0;

    load_stimulus(ok);
    cycle_limit = (send_bytes.size() + reply_bytes.size()) * 10 * BAUD_DIV * 2 + 2000;

    repeat (4) @(negedge clk);
    reset = 1'b0;

    if (!ok) begin
        stim_errors++;
    end else begin
        request_run_check("reset", 1'b0);
        sp = 0;
        rp = 0;
        for (t = 0; t < test_names.size(); t++) begin
            exp_name = name_bits(test_names[t]);
            for (k = 0; k < reply_counts[t]; k++) begin
                exp_vld  = 1'b1;
                exp_byte = reply_bytes[rp];
                rp++;
                @(negedge clk);
            end
            exp_vld = 1'b0;
            for (k = 0; k < send_counts[t]; k++) begin
                send_byte(send_bytes[sp]);
                sp++;
            end
            do begin
                @(negedge clk);
            end while (!reply_idle);
            request_run_check(test_names[t], exp_runs[t]);
        end
    end
    end_run();
end

// Run limit from the length of the stimulus
initial begin
    timeout_errors = 0;
    cycles = 0;
    @(posedge clk);
    while (cycles < cycle_limit) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout waiting for reply after %0d cycles", cycles);
    timeout_errors = 1;
    end_run();
end

endmodule

// ==== verilog.f ====
rtl/soc_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/ram.sv
rtl/ram_loader.sv
rtl/soc_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --top-module tb_top -f verilog.f -Mdir obj_dir -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim | tee sim.log

grep -qx "Test OK" sim.log 2>/dev/null &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== testbench/uart_stimulus.txt ====
# name  sent_bytes  reply_bytes  cpu_run_after
# bytes are hex in line order, separated by ':'
wr_iram_0 10:00:00:00:00:44:33:22:11 aa 0
wr_dram_0 11:00:00:00:00:5a:5a:a5:a5 aa 0
wr_iram_40 10:40:00:00:00:ef:be:ad:de aa 0
wr_dram_3fc 11:fc:03:00:00:04:03:02:01 aa 0
rd_iram_0 20:00:00:00:00 44:33:22:11 0
rd_dram_0 21:00:00:00:00 5a:5a:a5:a5 0
rd_iram_40 20:40:00:00:00 ef:be:ad:de 0
rd_dram_3fc 21:fc:03:00:00 04:03:02:01 0
rewr_iram_40 10:40:00:00:00:0d:f0:fe:ca aa 0
rerd_iram_40 20:40:00:00:00 0d:f0:fe:ca 0
rerd_iram_0 20:00:00:00:00 44:33:22:11 0
wrap_wr_dram 11:04:14:00:00:44:55:66:77 aa 0
wrap_rd_dram_4 21:04:00:00:00 44:55:66:77 0
wrap_rd_dram_hi 21:fc:ff:ff:ff 04:03:02:01 0
run 30 aa 1
rd_while_run 21:00:00:00:00 5a:5a:a5:a5 1
halt 31 aa 0
bad_op_55 55 ee 0
after_bad_wr 11:08:00:00:00:0d:f0:ad:0b aa 0
after_bad_rd 21:08:00:00:00 0d:f0:ad:0b 0
run_again 30 aa 1
bad_op_00 00 ee 1
halt_again 31 aa 0
bad_op_ff ff ee 0
wr_after_ff 10:fc:03:00:00:78:56:34:12 aa 0
rd_after_ff 20:fc:03:00:00 78:56:34:12 0
